//--- common/cpu_pkg.sv
package cpu_pkg;

  // data and address word
  typedef logic [31:0] word_t;

  // register file sizing
  localparam int REG_COUNT = 32;
  localparam int REG_W = $clog2(REG_COUNT);
  typedef logic [REG_W-1:0] regaddr_t;

  // fetch starts here out of reset
  localparam word_t RESET_PC = 32'h0000_0000;

  // supported primary opcodes
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ORI   = 6'h0d,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b,
    OP_HALT  = 6'h3f
  } opcode_t;

  // r-type function codes
  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_t;

  // alu operations, lui moves b into the upper half
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } alu_op_t;

  // writeback source
  typedef enum logic {
    WB_ALU,
    WB_LOAD
  } wb_sel_t;

  // control transfer kind, resolved in execute
  typedef enum logic [1:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_J
  } br_kind_t;

  // one instruction word, seen as r fields or i fields
  typedef union packed {
    struct packed {
      opcode_t  opcode;
      regaddr_t rs;
      regaddr_t rt;
      regaddr_t rd;
      logic [4:0] shamt;
      funct_t   funct;
    } r;
    struct packed {
      opcode_t  opcode;
      regaddr_t rs;
      regaddr_t rt;
      logic [15:0] imm;
    } i;
  } instr_u;

endpackage

//--- common/pipe_if.sv
`timescale 1ns/1ns

// decode/execute pipeline register contents
interface dx_if
  import cpu_pkg::*;
();
  logic     valid;
  alu_op_t  alu_op;
  wb_sel_t  wb_sel;
  br_kind_t br_kind;
  logic     reg_wen;
  logic     mem_ren;
  logic     mem_wen;
  logic     halt;
  regaddr_t rs;
  regaddr_t rt;
  regaddr_t wsel;
  word_t    rdat1;
  word_t    rdat2;
  word_t    imm_ext;
  logic     use_imm;
  word_t    npc;
  word_t    jtarget;

  modport decode (
    output valid, alu_op, wb_sel, br_kind, reg_wen, mem_ren, mem_wen, halt,
           rs, rt, wsel, rdat1, rdat2, imm_ext, use_imm, npc, jtarget
  );

  modport execute (
    input valid, alu_op, wb_sel, br_kind, reg_wen, mem_ren, mem_wen, halt,
          rs, rt, wsel, rdat1, rdat2, imm_ext, use_imm, npc, jtarget
  );
endinterface

// execute/memory pipeline register contents
interface xm_if
  import cpu_pkg::*;
();
  logic     valid;
  word_t    alu_out;
  word_t    store_data;
  regaddr_t wsel;
  logic     reg_wen;
  logic     mem_ren;
  logic     mem_wen;
  wb_sel_t  wb_sel;
  logic     halt;

  modport execute (
    output valid, alu_out, store_data, wsel, reg_wen, mem_ren, mem_wen, wb_sel, halt
  );

  modport memory (
    input valid, alu_out, store_data, wsel, reg_wen, mem_ren, mem_wen, wb_sel, halt
  );
endinterface

//--- decode/register_file.sv
`timescale 1ns/1ns

module register_file
  import cpu_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  logic     wen,
  input  regaddr_t wsel,
  input  word_t    wdat,
  input  regaddr_t rsel1,
  input  regaddr_t rsel2,
  output word_t    rdat1,
  output word_t    rdat2
);

  word_t regs [REG_COUNT];

  // register 0 never written
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      for (int k = 0; k < REG_COUNT; k++)
        regs[k] <= '0;
    end
    else if (wen && wsel != '0)
      regs[wsel] <= wdat;
  end

  // same-cycle write shows up on the read ports
  assign rdat1 = (rsel1 == '0) ? '0 : (wen && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 : (wen && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

//--- decode/decode_unit.sv
`timescale 1ns/1ns

module decode_unit
  import cpu_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  word_t    fd_instr,
  input  word_t    fd_npc,
  input  logic     fd_valid,
  input  logic     mem_stall,
  input  logic     redirect,
  input  logic     wb_wen,
  input  regaddr_t wb_wsel,
  input  word_t    wb_data,
  output logic     load_stall,
  dx_if.decode     dx
);

  instr_u   ins;
  alu_op_t  alu_op;
  wb_sel_t  wb_sel;
  br_kind_t br_kind;
  logic     reg_wen;
  logic     mem_ren;
  logic     mem_wen;
  logic     halt_op;
  logic     use_imm;
  logic     zero_ext;
  logic     dst_rd;
  logic     uses_rs;
  logic     uses_rt;
  word_t    rdat1;
  word_t    rdat2;
  word_t    imm_ext;
  word_t    jtarget;
  regaddr_t wsel;

  assign ins = fd_instr;

  register_file i_regs (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (wb_wen),
    .wsel  (wb_wsel),
    .wdat  (wb_data),
    .rsel1 (ins.r.rs),
    .rsel2 (ins.r.rt),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  // control decode
  always_comb
  begin
    alu_op   = ALU_ADD;
    wb_sel   = WB_ALU;
    br_kind  = BR_NONE;
    reg_wen  = 1'b0;
    mem_ren  = 1'b0;
    mem_wen  = 1'b0;
    halt_op  = 1'b0;
    use_imm  = 1'b1;
    zero_ext = 1'b0;
    dst_rd   = 1'b0;
    uses_rs  = 1'b1;
    uses_rt  = 1'b0;
    case (ins.r.opcode)
      OP_RTYPE:
      begin
        use_imm = 1'b0;
        dst_rd  = 1'b1;
        uses_rt = 1'b1;
        // unknown funct acts as a nop
        reg_wen = 1'b1;
        case (ins.r.funct)
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_SLT:  alu_op = ALU_SLT;
          default: reg_wen = 1'b0;
        endcase
      end
      OP_ADDIU: reg_wen = 1'b1;
      OP_ORI:
      begin
        alu_op   = ALU_OR;
        zero_ext = 1'b1;
        reg_wen  = 1'b1;
      end
      OP_LUI:
      begin
        alu_op   = ALU_LUI;
        zero_ext = 1'b1;
        reg_wen  = 1'b1;
        uses_rs  = 1'b0;
      end
      OP_LW:
      begin
        mem_ren = 1'b1;
        wb_sel  = WB_LOAD;
        reg_wen = 1'b1;
      end
      OP_SW:
      begin
        mem_wen = 1'b1;
        uses_rt = 1'b1;
      end
      OP_BEQ, OP_BNE:
      begin
        // compare rs with rt, imm only feeds the target
        br_kind = (ins.r.opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
        use_imm = 1'b0;
        uses_rt = 1'b1;
      end
      OP_J:
      begin
        br_kind = BR_J;
        uses_rs = 1'b0;
      end
      OP_HALT:
      begin
        halt_op = 1'b1;
        uses_rs = 1'b0;
      end
      default: uses_rs = 1'b0;
    endcase
  end

  assign imm_ext = zero_ext ? {16'h0000, ins.i.imm} : {{16{ins.i.imm[15]}}, ins.i.imm};
  // 26-bit target spans rs, rt and imm of the i view
  assign jtarget = {fd_npc[31:28], ins.i.rs, ins.i.rt, ins.i.imm, 2'b00};
  assign wsel = dst_rd ? ins.r.rd : ins.i.rt;

  // load in execute feeding a source of this instruction
  assign load_stall = fd_valid && dx.valid && dx.mem_ren && (dx.wsel != '0) &&
                      ((uses_rs && dx.wsel == ins.r.rs) || (uses_rt && dx.wsel == ins.r.rt));

  // decode/execute valid, flushed or bubbled
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      dx.valid <= 1'b0;
    else if (!mem_stall)
      dx.valid <= fd_valid && !redirect && !load_stall;
  end

  // decode/execute payload
  always_ff @(posedge CLK)
  begin
    if (!mem_stall)
    begin
      dx.alu_op  <= alu_op;
      dx.wb_sel  <= wb_sel;
      dx.br_kind <= br_kind;
      dx.reg_wen <= reg_wen;
      dx.mem_ren <= mem_ren;
      dx.mem_wen <= mem_wen;
      dx.halt    <= halt_op;
      dx.rs      <= ins.r.rs;
      dx.rt      <= ins.r.rt;
      dx.wsel    <= wsel;
      dx.rdat1   <= rdat1;
      dx.rdat2   <= rdat2;
      dx.imm_ext <= imm_ext;
      dx.use_imm <= use_imm;
      dx.npc     <= fd_npc;
      dx.jtarget <= jtarget;
    end
  end

endmodule

//--- execute/execute_unit.sv
`timescale 1ns/1ns

module execute_unit
  import cpu_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  logic     mem_stall,
  input  logic     wb_wen,
  input  regaddr_t wb_wsel,
  input  word_t    wb_data,
  output logic     redirect,
  output word_t    redirect_pc,
  dx_if.execute    dx,
  xm_if.execute    xm
);

  logic  xm_fwd;
  logic  wb_fwd;
  word_t opa;
  word_t src_b;
  word_t opb;
  word_t alu_out;
  logic  equal;

  // memory stage result, loads excluded by the load-use stall
  assign xm_fwd = xm.valid && xm.reg_wen && !xm.mem_ren && (xm.wsel != '0);
  assign wb_fwd = wb_wen && (wb_wsel != '0);

  // newest producer wins
  function automatic word_t fwd(input regaddr_t sel, input word_t rf_val);
    word_t val;
    val = rf_val;
    if (xm_fwd && xm.wsel == sel)
      val = xm.alu_out;
    else if (wb_fwd && wb_wsel == sel)
      val = wb_data;
    return val;
  endfunction

  assign opa   = fwd(dx.rs, dx.rdat1);
  // rt value also carries the store data
  assign src_b = fwd(dx.rt, dx.rdat2);
  assign opb   = dx.use_imm ? dx.imm_ext : src_b;

  always_comb
  begin
    case (dx.alu_op)
      ALU_ADD: alu_out = opa + opb;
      ALU_SUB: alu_out = opa - opb;
      ALU_AND: alu_out = opa & opb;
      ALU_OR:  alu_out = opa | opb;
      ALU_SLT: alu_out = {31'b0, $signed(opa) < $signed(opb)};
      ALU_LUI: alu_out = {opb[15:0], 16'h0000};
      default: alu_out = opa + opb;
    endcase
  end

  // branch compare on forwarded operands
  assign equal = (opa == src_b);

  always_comb
  begin
    case (dx.br_kind)
      BR_BEQ:  redirect = dx.valid && equal;
      BR_BNE:  redirect = dx.valid && !equal;
      BR_J:    redirect = dx.valid;
      default: redirect = 1'b0;
    endcase
  end

  // branch offset counts words past npc
  assign redirect_pc = (dx.br_kind == BR_J) ? dx.jtarget : dx.npc + {dx.imm_ext[29:0], 2'b00};

  // taken branch leaves a bubble behind
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      xm.valid <= 1'b0;
    else if (!mem_stall)
      xm.valid <= dx.valid && !redirect;
  end

  always_ff @(posedge CLK)
  begin
    if (!mem_stall)
    begin
      xm.alu_out    <= alu_out;
      xm.store_data <= src_b;
      xm.wsel       <= dx.wsel;
      xm.reg_wen    <= dx.reg_wen;
      xm.mem_ren    <= dx.mem_ren;
      xm.mem_wen    <= dx.mem_wen;
      xm.wb_sel     <= dx.wb_sel;
      xm.halt       <= dx.halt;
    end
  end

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit
  import cpu_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  mem_stall,
  input  logic  load_stall,
  input  logic  redirect,
  input  word_t redirect_pc,
  input  logic  halted,
  output word_t imem_addr,
  input  word_t imem_data,
  output word_t fd_instr,
  output word_t fd_npc,
  output logic  fd_valid
);

  word_t pc;
  word_t pc_plus4;

  assign pc_plus4 = pc + 32'd4;
  // instruction memory answers in the same cycle
  assign imem_addr = pc;

  // pc select, memory freeze first, then redirect, then hold
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      pc <= RESET_PC;
    else if (mem_stall)
      pc <= pc;
    else if (redirect)
      pc <= redirect_pc;
    else if (!load_stall && !halted)
      pc <= pc_plus4;
  end

  // fetch/decode valid bit
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      fd_valid <= 1'b0;
    else if (!mem_stall)
    begin
      // squash the wrong-path word on redirect
      if (redirect || halted)
        fd_valid <= 1'b0;
      else if (!load_stall)
        fd_valid <= 1'b1;
    end
  end

  // fetch/decode payload
  always_ff @(posedge CLK)
  begin
    if (!mem_stall && !redirect && !load_stall)
    begin
      fd_instr <= imem_data;
      fd_npc   <= pc_plus4;
    end
  end

endmodule

//--- verilog/memory_stage.sv
`timescale 1ns/1ns

module memory_stage
  import cpu_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  word_t    dmem_load,
  input  logic     dmem_hit,
  output logic     dmem_ren,
  output logic     dmem_wen,
  output word_t    dmem_addr,
  output word_t    dmem_store,
  output logic     mem_stall,
  output logic     halt,
  output logic     wb_wen,
  output regaddr_t wb_wsel,
  output word_t    wb_data,
  xm_if.memory     xm
);

  logic     active;
  logic     mw_valid;
  logic     mw_reg_wen;
  regaddr_t mw_wsel;
  wb_sel_t  mw_wb_sel;
  word_t    mw_alu;
  word_t    mw_load;

  // nothing behind a retired halt touches memory or registers
  assign active = xm.valid && !halt;

  // request held with stable address and data until the hit
  assign dmem_ren   = active && xm.mem_ren;
  assign dmem_wen   = active && xm.mem_wen;
  assign dmem_addr  = xm.alu_out;
  assign dmem_store = xm.store_data;
  assign mem_stall  = (dmem_ren || dmem_wen) && !dmem_hit;

  // memory/writeback control
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      mw_valid   <= 1'b0;
      mw_reg_wen <= 1'b0;
    end
    else if (!mem_stall)
    begin
      mw_valid   <= active;
      mw_reg_wen <= xm.reg_wen;
    end
  end

  // memory/writeback payload, load data taken on the hit cycle
  always_ff @(posedge CLK)
  begin
    if (!mem_stall)
    begin
      mw_wsel   <= xm.wsel;
      mw_wb_sel <= xm.wb_sel;
      mw_alu    <= xm.alu_out;
      mw_load   <= dmem_load;
    end
  end

  // writeback bundle, also the far forwarding source
  assign wb_wen  = mw_valid && mw_reg_wen;
  assign wb_wsel = mw_wsel;
  assign wb_data = (mw_wb_sel == WB_LOAD) ? mw_load : mw_alu;

  // sticky once a valid halt leaves memory
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      halt <= 1'b0;
    else if (active && xm.halt)
      halt <= 1'b1;
  end

endmodule

//--- verilog/cpu_core.sv
`timescale 1ns/1ns

module cpu_core
  import cpu_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  output word_t imem_addr,
  input  word_t imem_data,
  output logic  dmem_ren,
  output logic  dmem_wen,
  output word_t dmem_addr,
  output word_t dmem_store,
  input  word_t dmem_load,
  input  logic  dmem_hit,
  output logic  halt
);

  word_t    fd_instr;
  word_t    fd_npc;
  logic     fd_valid;
  logic     load_stall;
  logic     redirect;
  word_t    redirect_pc;
  logic     mem_stall;
  logic     wb_wen;
  regaddr_t wb_wsel;
  word_t    wb_data;

  // stage buses
  dx_if dx ();
  xm_if xm ();

  fetch_unit i_fetch (
    .CLK         (CLK),
    .nRST        (nRST),
    .mem_stall   (mem_stall),
    .load_stall  (load_stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halted      (halt),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .fd_instr    (fd_instr),
    .fd_npc      (fd_npc),
    .fd_valid    (fd_valid)
  );

  decode_unit i_decode (
    .CLK        (CLK),
    .nRST       (nRST),
    .fd_instr   (fd_instr),
    .fd_npc     (fd_npc),
    .fd_valid   (fd_valid),
    .mem_stall  (mem_stall),
    .redirect   (redirect),
    .wb_wen     (wb_wen),
    .wb_wsel    (wb_wsel),
    .wb_data    (wb_data),
    .load_stall (load_stall),
    .dx         (dx.decode)
  );

  execute_unit i_execute (
    .CLK         (CLK),
    .nRST        (nRST),
    .mem_stall   (mem_stall),
    .wb_wen      (wb_wen),
    .wb_wsel     (wb_wsel),
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .dx          (dx.execute),
    .xm          (xm.execute)
  );

  // also drives the freeze seen by every stage
  memory_stage i_memory (
    .CLK        (CLK),
    .nRST       (nRST),
    .dmem_load  (dmem_load),
    .dmem_hit   (dmem_hit),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .mem_stall  (mem_stall),
    .halt       (halt),
    .wb_wen     (wb_wen),
    .wb_wsel    (wb_wsel),
    .wb_data    (wb_data),
    .xm         (xm.memory)
  );

endmodule

//--- verification/cpu_chk.sv
`timescale 1ns/1ns

module cpu_chk
  import cpu_pkg::*;
(
  input logic  CLK,
  input logic  nRST,
  input logic  dmem_ren,
  input logic  dmem_wen,
  input logic  dmem_hit,
  input word_t dmem_addr,
  input word_t dmem_store
);

  int fail_count = 0;

  // pending request keeps its kind and address until the hit
  a_req_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (dmem_ren || dmem_wen) && !dmem_hit |=>
      $stable(dmem_ren) && $stable(dmem_wen) && $stable(dmem_addr))
    else
    begin
      fail_count++;
      $error("data request or address changed before its hit");
    end

  // store data too
  a_store_hold: assert property (@(posedge CLK) disable iff (!nRST)
    dmem_wen && !dmem_hit |=> $stable(dmem_store))
    else
    begin
      fail_count++;
      $error("store data changed before its hit");
    end

  a_rw_excl: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_ren && dmem_wen))
    else
    begin
      fail_count++;
      $error("read and write requested together");
    end

endmodule

bind memory_stage cpu_chk i_chk (
  .CLK        (CLK),
  .nRST       (nRST),
  .dmem_ren   (dmem_ren),
  .dmem_wen   (dmem_wen),
  .dmem_hit   (dmem_hit),
  .dmem_addr  (dmem_addr),
  .dmem_store (dmem_store)
);

//--- verification/cpu_monitor.sv
`timescale 1ns/1ns

module cpu_monitor
  import cpu_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  dmem_wen,
  input  logic  dmem_hit,
  input  word_t dmem_addr,
  input  word_t dmem_store,
  input  logic  halt,
  input  word_t golden [128],
  input  logic  run_done,
  output logic  checked,
  output int    mismatch_count,
  output int    other_count
);

  int   store_idx;
  logic halt_seen;

  function automatic word_t gold_at(input int n);
    return golden[n[6:0]];
  endfunction

  // records start after the program and the count word
  function automatic int record_pos(input int k);
    return int'(golden[0]) + 2 + 2 * k;
  endfunction

  // a store completes on the cycle its hit is high
  always @(posedge CLK, negedge nRST)
  begin : compare
    int add_mm;
    int add_other;
    int exp_count;
    if (!nRST)
    begin
      store_idx      <= 0;
      halt_seen      <= 1'b0;
      checked        <= 1'b0;
      mismatch_count <= 0;
      other_count    <= 0;
    end
    else
    begin
      add_mm = 0;
      add_other = 0;
      exp_count = int'(gold_at(int'(golden[0]) + 1));
      if (dmem_wen && dmem_hit)
      begin
        if (halt)
        begin
          $display("store to %h happened after halt", dmem_addr);
          add_other++;
        end
        else if (store_idx >= exp_count)
        begin
          $display("extra store to %h, only %0d expected", dmem_addr, exp_count);
          add_other++;
        end
        else
        begin
          if (dmem_addr !== gold_at(record_pos(store_idx)))
          begin
            $display("MISMATCH dmem_addr store %0d: expected %h got %h",
                     store_idx, gold_at(record_pos(store_idx)), dmem_addr);
            add_mm++;
          end
          if (dmem_store !== gold_at(record_pos(store_idx) + 1))
          begin
            $display("MISMATCH dmem_store store %0d: expected %h got %h",
                     store_idx, gold_at(record_pos(store_idx) + 1), dmem_store);
            add_mm++;
          end
        end
        store_idx <= store_idx + 1;
      end
      // halt is sticky
      if (halt_seen && !halt)
      begin
        $display("halt fell again after it had risen");
        add_other++;
      end
      halt_seen <= halt_seen || halt;
      if (run_done && !checked)
      begin
        if (store_idx != exp_count)
        begin
          $display("saw %0d stores but expected %0d", store_idx, exp_count);
          add_other++;
        end
        checked <= 1'b1;
      end
      mismatch_count <= mismatch_count + add_mm;
      other_count    <= other_count + add_other;
    end
  end

endmodule

//--- verification/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb
  import cpu_pkg::*;
();

  // golden image depth, program plus store records
  localparam int GOLD_DEPTH = 128;
  // idle cycles after halt so a late store still gets caught
  localparam int DRAIN_CYCLES = 8;

  logic        CLK;
  logic        nRST = 1'b0;
  word_t       imem_addr;
  word_t       imem_data;
  logic        dmem_ren;
  logic        dmem_wen;
  word_t       dmem_addr;
  word_t       dmem_store;
  word_t       dmem_load = '0;
  logic        dmem_hit = 1'b0;
  logic        halt;

  word_t       golden [GOLD_DEPTH];
  word_t       ram [word_t];
  word_t       prog_len;
  logic [15:0] lfsr = 16'd17;
  logic        busy = 1'b0;
  logic [1:0]  wait_left = 2'd0;
  int          cycle_count = 0;
  int          limit;
  int          timeout_count;
  logic        run_done = 1'b0;
  logic        checked;
  int          mismatch_count;
  int          other_count;

  cpu_core i_dut (
    .CLK        (CLK),
    .nRST       (nRST),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .dmem_load  (dmem_load),
    .dmem_hit   (dmem_hit),
    .halt       (halt)
  );

  cpu_monitor i_monitor (
    .CLK            (CLK),
    .nRST           (nRST),
    .dmem_wen       (dmem_wen),
    .dmem_hit       (dmem_hit),
    .dmem_addr      (dmem_addr),
    .dmem_store     (dmem_store),
    .halt           (halt),
    .golden         (golden),
    .run_done       (run_done),
    .checked        (checked),
    .mismatch_count (mismatch_count),
    .other_count    (other_count)
  );

  // galois lfsr, taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // unwritten ram words, pattern spans every address bit
  function automatic word_t fill_word(input word_t a);
    return {a[15:0], a[31:16]} ^ 32'h5A3C_C3A5;
  endfunction

  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK)
    cycle_count <= cycle_count + 1;

  // word 0 holds the program length, program follows
  assign prog_len = golden[0];
  // rom answers combinationally, nop past the end
  assign imem_data = ({2'b00, imem_addr[31:2]} < prog_len) ? golden[imem_addr[8:2] + 7'd1] : '0;

  // data ram, hit after 0 to 3 extra cycles of wait
  always @(posedge CLK)
  begin : data_ram
    logic [15:0] s;
    logic [1:0]  wait_now;
    s = lfsr;
    wait_now = wait_left;
    if (!nRST)
    begin
      dmem_hit <= 1'b0;
      busy     <= 1'b0;
    end
    else if (dmem_hit)
      dmem_hit <= 1'b0;
    else if (dmem_ren || dmem_wen)
    begin
      // fresh access, two bits of wait
      if (!busy)
      begin
        wait_now[0] = s[0];
        s = lfsr_step(s);
        wait_now[1] = s[0];
        s = lfsr_step(s);
        lfsr <= s;
      end
      if (wait_now == 2'd0)
      begin
        dmem_hit <= 1'b1;
        busy     <= 1'b0;
        if (dmem_wen)
          ram[dmem_addr] = dmem_store;
        else
          dmem_load <= ram.exists(dmem_addr) ? ram[dmem_addr] : fill_word(dmem_addr);
      end
      else
      begin
        busy      <= 1'b1;
        wait_left <= wait_now - 2'd1;
      end
    end
  end

  initial
  begin
    $readmemh("verification/cpu_golden.hex", golden);
    limit = int'(golden[0]) * 8 + 100;
    timeout_count = 0;
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    // sample between edges
    while (!halt && cycle_count < limit)
      @(negedge CLK);
    if (!halt)
    begin
      $display("timeout: halt did not rise within %0d cycles", limit);
      timeout_count = 1;
    end
    else
    begin
      repeat (DRAIN_CYCLES) @(negedge CLK);
      run_done <= 1'b1;
      while (!checked && cycle_count < limit + DRAIN_CYCLES + 4)
        @(negedge CLK);
      if (!checked)
      begin
        $display("timeout: final store count check never completed");
        timeout_count = 1;
      end
    end
    $display("errors: mismatch=%0d other=%0d assert=%0d timeout=%0d",
             mismatch_count, other_count, i_dut.i_memory.i_chk.fail_count, timeout_count);
    if (mismatch_count == 0 && other_count == 0 && i_dut.i_memory.i_chk.fail_count == 0 &&
        timeout_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- verification/cpu_golden.hex
// one 32-bit hex word per entry: program length, program words,
// store count, then expected store records as address and data
00000027 // program length, 39 words
24010005 // 00 addiu r1, r0, 5
2402fffd // 01 addiu r2, r0, -3
00221821 // 02 addu  r3, r1, r2
00222023 // 03 subu  r4, r1, r2
00222824 // 04 and   r5, r1, r2
00223025 // 05 or    r6, r1, r2
0041382a // 06 slt   r7, r2, r1
34088001 // 07 ori   r8, r0, 0x8001
3c091234 // 08 lui   r9, 0x1234
35295678 // 09 ori   r9, r9, 0x5678
240a0100 // 10 addiu r10, r0, 0x100
ad430000 // 11 sw    r3, 0(r10)
ad440004 // 12 sw    r4, 4(r10)
ad450008 // 13 sw    r5, 8(r10)
ad46000c // 14 sw    r6, 12(r10)
ad470010 // 15 sw    r7, 16(r10)
ad480014 // 16 sw    r8, 20(r10)
ad490018 // 17 sw    r9, 24(r10)
244b0007 // 18 addiu r11, r2, 7
ad4b001c // 19 sw    r11, 28(r10)
8d4c0018 // 20 lw    r12, 24(r10)
01816821 // 21 addu  r13, r12, r1
25af0001 // 22 addiu r15, r13, 1
ad4d0020 // 23 sw    r13, 32(r10)
ad4f0024 // 24 sw    r15, 36(r10)
10210002 // 25 beq   r1, r1, +2
ad400028 // 26 sw    r0, 40(r10), skipped
ad40002c // 27 sw    r0, 44(r10), skipped
14210002 // 28 bne   r1, r1, +2, falls through
240e0077 // 29 addiu r14, r0, 0x77
15c00002 // 30 bne   r14, r0, +2
ad4e0030 // 31 sw    r14, 48(r10), skipped
ad4e0034 // 32 sw    r14, 52(r10), skipped
08000024 // 33 j     word 36
ad400038 // 34 sw    r0, 56(r10), skipped
ad40003c // 35 sw    r0, 60(r10), skipped
ad4e0040 // 36 sw    r14, 64(r10)
fc000000 // 37 halt
ad410044 // 38 sw    r1, 68(r10), after halt
0000000b // expected store count
00000100 00000002 // addu
00000104 00000008 // subu
00000108 00000005 // and
0000010c fffffffd // or
00000110 00000001 // slt
00000114 00008001 // ori zero extended
00000118 12345678 // lui then ori
0000011c 00000004 // addiu sign extended
00000120 1234567d // load then dependent addu
00000124 1234567e // forwarded addiu
00000140 00000077 // after branches and jump

//--- compile.f
common/cpu_pkg.sv
common/pipe_if.sv
decode/register_file.sv
decode/decode_unit.sv
execute/execute_unit.sv
verilog/fetch_unit.sv
verilog/memory_stage.sv
verilog/cpu_core.sv
verification/cpu_chk.sv
verification/cpu_monitor.sv
verification/cpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module cpu_tb -f compile.f -o cpu_sim

out=$(./obj_dir/cpu_sim +verilator+error+limit+100)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"
then
  exit 0
fi
exit 1
